// ==== src/isaPkg.sv ====
// Instruction-set encodings shared by the control unit blocks and their testbench
`default_nettype none

package isaPkg;

    localparam int OPCODE_W    = 6;
    localparam int ALU_OP_W    = 4;
    localparam int BRANCH_OP_W = 3;
    localparam int STACK_OP_W  = 3;

    // Opcode values of the existing instruction set
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'b000000,
        OP_ADDI  = 6'b000001,
        OP_SUBI  = 6'b000010,
        OP_ANDI  = 6'b000011,
        OP_ORI   = 6'b000100,
        OP_XORI  = 6'b000101,
        OP_NOTI  = 6'b000110,
        OP_SLAI  = 6'b000111,
        OP_SRLI  = 6'b001000,
        OP_SRAI  = 6'b001001,
        OP_BR    = 6'b001010,
        OP_BMI   = 6'b001011,
        OP_BPL   = 6'b001100,
        OP_BZ    = 6'b001101,
        OP_LD    = 6'b001110,
        OP_ST    = 6'b001111,
        OP_LDSP  = 6'b010000,
        OP_STSP  = 6'b010001,
        OP_MOVE  = 6'b010010,
        OP_PUSH  = 6'b010011,
        OP_POP   = 6'b010100,
        OP_CALL  = 6'b010101,
        OP_HALT  = 6'b010110,
        OP_NOP   = 6'b010111,
        OP_RET   = 6'b011000
    } opcodeT;

    // Instruction classes, each with its own strobe schedule
    typedef enum logic [3:0] {
        CLS_ALU_R,
        CLS_ALU_I,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_MOVE,
        CLS_PUSH,
        CLS_POP,
        CLS_CALL,
        CLS_RET,
        CLS_HALT,
        CLS_NOP
    } instrClassT;

    typedef enum logic [BRANCH_OP_W-1:0] {
        BR_NONE   = 3'd0,
        BR_ALWAYS = 3'd1,
        BR_PLUS   = 3'd2,
        BR_MINUS  = 3'd3,
        BR_ZERO   = 3'd4
    } branchOpT;

    typedef enum logic [STACK_OP_W-1:0] {
        STK_NONE = 3'd0,
        STK_PUSH = 3'd1,
        STK_POP  = 3'd2,
        STK_CALL = 3'd3,
        STK_RET  = 3'd4
    } stackOpT;

    typedef logic [ALU_OP_W-1:0] aluOpT;

    localparam aluOpT ALU_PASS = 4'd0;
    localparam aluOpT ALU_ADD  = 4'd1;

endpackage

`default_nettype wire

// ==== src/ctrlPkg.sv ====
// Sequencing types and per-class step counts used by the control unit FSM
`default_nettype none

package ctrlPkg;

    import isaPkg::*;

    localparam int MAX_STEPS = 6;
    localparam int STEP_W    = $clog2(MAX_STEPS);

    typedef enum logic {
        FETCH,
        EXEC
    } phaseT;

    // Execute-step index within one instruction
    typedef logic [STEP_W-1:0] stepT;

    // Number of execute cycles after the fetch cycle
    function automatic stepT stepCount(instrClassT cls);
        stepT n;
        case (cls)
            CLS_ALU_R, CLS_ALU_I, CLS_MOVE, CLS_BRANCH: n = stepT'(3);
            CLS_LOAD, CLS_STORE, CLS_PUSH, CLS_RET: n = stepT'(4);
            CLS_CALL: n = stepT'(5);
            CLS_POP: n = stepT'(6);
            // HALT waits in its first step, then finishes in the second
            CLS_HALT: n = stepT'(2);
            default: n = stepT'(2);
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire

// ==== src/opcodeDecoder.sv ====
// Opcode decoder; samples the opcode in the fetch cycle and holds class and datapath fields
`timescale 1ns/1ps
`default_nettype none

module opcodeDecoder import isaPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       fetch,
    input  opcodeT     opcode,
    output instrClassT instrClass,
    output branchOpT   branchOp,
    output aluOpT      aluOp,
    output logic       aluSrc,
    output stackOpT    stackOp
);

    instrClassT classNext;
    branchOpT   branchNext;
    stackOpT    stackNext;
    aluOpT      aluNext;
    logic       srcNext;

    // Class, branch and stack kind straight from the opcode
    always_comb begin
        classNext  = CLS_NOP;
        branchNext = BR_NONE;
        stackNext  = STK_NONE;
        case (opcode)
            OP_RTYPE: classNext = CLS_ALU_R;
            OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_XORI,
            OP_NOTI, OP_SLAI, OP_SRLI, OP_SRAI: classNext = CLS_ALU_I;
            OP_BR: begin
                classNext  = CLS_BRANCH;
                branchNext = BR_ALWAYS;
            end
            OP_BPL: begin
                classNext  = CLS_BRANCH;
                branchNext = BR_PLUS;
            end
            OP_BMI: begin
                classNext  = CLS_BRANCH;
                branchNext = BR_MINUS;
            end
            OP_BZ: begin
                classNext  = CLS_BRANCH;
                branchNext = BR_ZERO;
            end
            // SP-relative forms use the same schedule, SP arrives as Rt
            OP_LD, OP_LDSP: classNext = CLS_LOAD;
            OP_ST, OP_STSP: classNext = CLS_STORE;
            OP_MOVE: classNext = CLS_MOVE;
            OP_PUSH: begin
                classNext = CLS_PUSH;
                stackNext = STK_PUSH;
            end
            OP_POP: begin
                classNext = CLS_POP;
                stackNext = STK_POP;
            end
            OP_CALL: begin
                classNext = CLS_CALL;
                stackNext = STK_CALL;
            end
            OP_RET: begin
                classNext = CLS_RET;
                stackNext = STK_RET;
            end
            OP_HALT: classNext = CLS_HALT;
            OP_NOP: classNext = CLS_NOP;
            // Undefined opcodes run as NOP
            default: classNext = CLS_NOP;
        endcase
    end

    // ALU control; address, stack and branch work all need an add with immediate
    always_comb begin
        case (classNext)
            CLS_ALU_I: aluNext = aluOpT'(opcode[ALU_OP_W-1:0]);
            CLS_ALU_R, CLS_HALT, CLS_NOP: aluNext = ALU_PASS;
            default: aluNext = ALU_ADD;
        endcase
        srcNext = !(classNext inside {CLS_ALU_R, CLS_HALT, CLS_NOP});
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrClass <= CLS_NOP;
            branchOp   <= BR_NONE;
            aluOp      <= ALU_PASS;
            aluSrc     <= 1'b0;
            stackOp    <= STK_NONE;
        end else if (fetch) begin
            instrClass <= classNext;
            branchOp   <= branchNext;
            aluOp      <= aluNext;
            aluSrc     <= srcNext;
            stackOp    <= stackNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/stepCounter.sv ====
// Fetch/execute phase and step index of the multi-cycle sequencer
`timescale 1ns/1ps
`default_nettype none

module stepCounter import isaPkg::*, ctrlPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  lastStep,
    input  logic  hold,
    output phaseT phase,
    output stepT  step,
    output logic  fetch
);

    // Every instruction spends exactly one cycle in fetch
    assign fetch = (phase == FETCH);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= FETCH;
            step  <= '0;
        end else if (phase == FETCH) begin
            phase <= EXEC;
            step  <= '0;
        end else if (lastStep) begin
            // Wrap back for the next instruction
            phase <= FETCH;
            step  <= '0;
        end else if (!hold) begin
            step <= step + stepT'(1);
        end
    end

endmodule

`default_nettype wire

// ==== src/strobeScheduler.sv ====
// Strobe scheduler; turns class and execute step into timed memory, register and PC controls
`timescale 1ns/1ps
`default_nettype none

module strobeScheduler import isaPkg::*, ctrlPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  phaseT      phase,
    input  stepT       step,
    input  instrClassT instrClass,
    input  logic       intr,
    output logic       memRead,
    output logic       memWrite,
    output logic       regWrite,
    output logic       regDst,
    output logic       memToReg,
    output logic       updatePc,
    output logic       lastStep,
    output logic       hold
);

    logic inExec;
    stepT lastIdx;
    logic memReadNext;
    logic memWriteNext;
    logic regWriteNext;

    assign inExec  = (phase == EXEC);
    assign lastIdx = stepCount(instrClass) - stepT'(1);

    assign lastStep = inExec && (step == lastIdx);

    // HALT parks in its first step until an interrupt arrives
    assign hold = inExec && (instrClass == CLS_HALT) && (step == '0) && !intr;

    // Strobes are decided one step ahead and land in the following cycle
    always_comb begin
        memReadNext  = 1'b0;
        memWriteNext = 1'b0;
        regWriteNext = 1'b0;
        if (inExec) begin
            case (instrClass)
                CLS_ALU_R, CLS_ALU_I, CLS_MOVE: begin
                    regWriteNext = (step == stepT'(1));
                end
                CLS_LOAD: begin
                    memReadNext  = (step == stepT'(1));
                    regWriteNext = (step == stepT'(2));
                end
                CLS_STORE: begin
                    memWriteNext = (step == stepT'(2));
                end
                // SP update first, then the memory write
                CLS_PUSH, CLS_CALL: begin
                    regWriteNext = (step == stepT'(1));
                    memWriteNext = (step == stepT'(2));
                end
                // Two writes: popped data to Rt, then new SP to Rd
                CLS_POP: begin
                    memReadNext  = (step == stepT'(1));
                    regWriteNext = (step == stepT'(2)) || (step == stepT'(4));
                end
                CLS_RET: begin
                    memReadNext  = (step == stepT'(1));
                    regWriteNext = (step == stepT'(2));
                end
                default: begin
                    regWriteNext = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            regWrite <= 1'b0;
            updatePc <= 1'b0;
        end else begin
            memRead  <= memReadNext;
            memWrite <= memWriteNext;
            regWrite <= regWriteNext;
            // PC moves in the fetch cycle after the last step
            updatePc <= lastStep;
        end
    end

    // Level fields follow the current step, so they are valid from E0 on
    always_comb begin
        regDst   = 1'b0;
        memToReg = 1'b0;
        if (inExec) begin
            case (instrClass)
                CLS_ALU_R, CLS_PUSH, CLS_CALL, CLS_RET: begin
                    regDst = 1'b1;
                end
                CLS_LOAD: begin
                    memToReg = (step == stepT'(3));
                end
                // Memory data to Rt first, then SP to Rd
                CLS_POP: begin
                    memToReg = (step <= stepT'(3));
                    regDst   = (step >= stepT'(4));
                end
                default: begin
                    regDst = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
// Multi-cycle control unit top; connects decoder, step counter and strobe scheduler
`timescale 1ns/1ps
`default_nettype none

module controlUnit import isaPkg::*, ctrlPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  opcodeT   opcode,
    input  logic     intr,
    output branchOpT branchOp,
    output aluOpT    aluOp,
    output logic     aluSrc,
    output stackOpT  stackOp,
    output logic     memRead,
    output logic     memWrite,
    output logic     regWrite,
    output logic     regDst,
    output logic     memToReg,
    output logic     updatePc
);

    phaseT      phase;
    stepT       step;
    logic       fetch;
    logic       lastStep;
    logic       hold;
    instrClassT instrClass;

    opcodeDecoder i_decoder (
        .clk       (clk),
        .rstN      (rstN),
        .fetch     (fetch),
        .opcode    (opcode),
        .instrClass(instrClass),
        .branchOp  (branchOp),
        .aluOp     (aluOp),
        .aluSrc    (aluSrc),
        .stackOp   (stackOp)
    );

    stepCounter i_counter (
        .clk     (clk),
        .rstN    (rstN),
        .lastStep(lastStep),
        .hold    (hold),
        .phase   (phase),
        .step    (step),
        .fetch   (fetch)
    );

    strobeScheduler i_scheduler (
        .clk       (clk),
        .rstN      (rstN),
        .phase     (phase),
        .step      (step),
        .instrClass(instrClass),
        .intr      (intr),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .regWrite  (regWrite),
        .regDst    (regDst),
        .memToReg  (memToReg),
        .updatePc  (updatePc),
        .lastStep  (lastStep),
        .hold      (hold)
    );

endmodule

`default_nettype wire

// ==== tb/controlUnit_chk.sv ====
// Bound assertions on control unit strobes; attached to every controlUnit instance
`timescale 1ns/1ps
`default_nettype none

module controlUnitChk (
    input wire logic clk,
    input wire logic rstN,
    input wire logic memRead,
    input wire logic memWrite,
    input wire logic regWrite,
    input wire logic updatePc
);

    // One memory access direction at a time
    memExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(memRead && memWrite)
    ) else $error("memRead and memWrite are high together");

    // PC update is a single-cycle pulse
    pcSinglePulse: assert property (
        @(posedge clk) disable iff (!rstN) updatePc |=> !updatePc
    ) else $error("updatePc stayed high for two cycles");

    // Register writes never land in a fetch cycle
    noWriteOnPc: assert property (
        @(posedge clk) disable iff (!rstN) updatePc |-> !regWrite
    ) else $error("regWrite is high while updatePc is high");

endmodule

bind controlUnit controlUnitChk i_chk (
    .clk     (clk),
    .rstN    (rstN),
    .memRead (memRead),
    .memWrite(memWrite),
    .regWrite(regWrite),
    .updatePc(updatePc)
);

`default_nettype wire

// ==== tb/tbControlUnit.sv ====
// Testbench for the control unit; random opcodes from an LFSR checked against a cycle model
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit import isaPkg::*; ;

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_RANDOM     = 300;
    localparam int NUM_HALT       = 12;
    localparam int HALT_WAIT_MAX  = 20;
    localparam int TOTAL_INSTR    = NUM_RANDOM + NUM_HALT;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 8 * TOTAL_INSTR
                                    + HALT_WAIT_MAX * TOTAL_INSTR;

    // Model class codes
    localparam int C_ALU_R  = 0;
    localparam int C_ALU_I  = 1;
    localparam int C_BRANCH = 2;
    localparam int C_LOAD   = 3;
    localparam int C_STORE  = 4;
    localparam int C_MOVE   = 5;
    localparam int C_PUSH   = 6;
    localparam int C_POP    = 7;
    localparam int C_CALL   = 8;
    localparam int C_RET    = 9;
    localparam int C_HALT   = 10;
    localparam int C_NOP    = 11;

    logic     clk;
    logic     rstN;
    logic     intr;
    opcodeT   opcode;
    branchOpT branchOp;
    aluOpT    aluOp;
    logic     aluSrc;
    stackOpT  stackOp;
    logic     memRead;
    logic     memWrite;
    logic     regWrite;
    logic     regDst;
    logic     memToReg;
    logic     updatePc;

    logic [31:0] lfsrState;
    int errors;
    int checks;
    int cycleCount;

    // Model state for the cycle now in progress
    bit mIsFetch;
    bit mPulse;
    bit firstFetch;
    bit haltMode;
    bit havePulse;
    int mStep;
    int mCls;
    int mWait;
    int mInstrCycles;
    int lastLen;
    int sincePulse;
    int instrDone;
    int haltIndex;
    int pCls, pBranch, pAlu, pSrc, pStack;
    int eBranch, eAlu, eSrc, eStack;

    controlUnit i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .opcode  (opcode),
        .intr    (intr),
        .branchOp(branchOp),
        .aluOp   (aluOp),
        .aluSrc  (aluSrc),
        .stackOp (stackOp),
        .memRead (memRead),
        .memWrite(memWrite),
        .regWrite(regWrite),
        .regDst  (regDst),
        .memToReg(memToReg),
        .updatePc(updatePc)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = (v << 1) | int'(lfsrState[0]);
        end
    endtask

    function automatic int decodeClass(input opcodeT op);
        int c;
        case (op)
            OP_RTYPE: c = C_ALU_R;
            OP_ADDI, OP_SUBI, OP_ANDI, OP_ORI, OP_XORI,
            OP_NOTI, OP_SLAI, OP_SRLI, OP_SRAI: c = C_ALU_I;
            OP_BR, OP_BMI, OP_BPL, OP_BZ: c = C_BRANCH;
            OP_LD, OP_LDSP: c = C_LOAD;
            OP_ST, OP_STSP: c = C_STORE;
            OP_MOVE: c = C_MOVE;
            OP_PUSH: c = C_PUSH;
            OP_POP: c = C_POP;
            OP_CALL: c = C_CALL;
            OP_RET: c = C_RET;
            OP_HALT: c = C_HALT;
            default: c = C_NOP;
        endcase
        return c;
    endfunction

    function automatic int branchFor(input opcodeT op);
        int b;
        case (op)
            OP_BR: b = 1;
            OP_BPL: b = 2;
            OP_BMI: b = 3;
            OP_BZ: b = 4;
            default: b = 0;
        endcase
        return b;
    endfunction

    function automatic int stackFor(input int c);
        int s;
        case (c)
            C_PUSH: s = 1;
            C_POP: s = 2;
            C_CALL: s = 3;
            C_RET: s = 4;
            default: s = 0;
        endcase
        return s;
    endfunction

    function automatic int stepsFor(input int c);
        int n;
        case (c)
            C_LOAD, C_STORE, C_PUSH, C_RET: n = 4;
            C_CALL: n = 5;
            C_POP: n = 6;
            C_HALT, C_NOP: n = 2;
            default: n = 3;
        endcase
        return n;
    endfunction

    task automatic checkVal(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compareOutputs();
        int eRd, eWr, eRw, eDst, eM2r;
        eRd  = 0;
        eWr  = 0;
        eRw  = 0;
        eDst = 0;
        eM2r = 0;
        if (!mIsFetch) begin
            case (mCls)
                C_ALU_R: begin
                    eRw  = int'(mStep == 2);
                    eDst = 1;
                end
                C_ALU_I, C_MOVE: eRw = int'(mStep == 2);
                C_LOAD: begin
                    eRd  = int'(mStep == 2);
                    eRw  = int'(mStep == 3);
                    eM2r = int'(mStep == 3);
                end
                C_STORE: eWr = int'(mStep == 3);
                C_PUSH, C_CALL: begin
                    eRw  = int'(mStep == 2);
                    eWr  = int'(mStep == 3);
                    eDst = 1;
                end
                // Data into Rt first, then the new SP into Rd
                C_POP: begin
                    eRd  = int'(mStep == 2);
                    eRw  = int'(mStep == 3 || mStep == 5);
                    eM2r = int'(mStep <= 3);
                    eDst = int'(mStep >= 4);
                end
                C_RET: begin
                    eRd  = int'(mStep == 2);
                    eRw  = int'(mStep == 3);
                    eDst = 1;
                end
                default: eRd = 0;
            endcase
        end
        checkVal("memRead", int'(memRead), eRd);
        checkVal("memWrite", int'(memWrite), eWr);
        checkVal("regWrite", int'(regWrite), eRw);
        checkVal("regDst", int'(regDst), eDst);
        checkVal("memToReg", int'(memToReg), eM2r);
        checkVal("updatePc", int'(updatePc), int'(mPulse));
        checkVal("branchOp", int'(branchOp), eBranch);
        checkVal("aluOp", int'(aluOp), eAlu);
        checkVal("aluSrc", int'(aluSrc), eSrc);
        checkVal("stackOp", int'(stackOp), eStack);
        sincePulse++;
        if (updatePc === 1'b1) begin
            if (havePulse && sincePulse != lastLen) begin
                errors++;
                $display("mismatch at %0t: updatePc interval is %0d, expected %0d",
                         $time, sincePulse, lastLen);
            end
            havePulse  = 1'b1;
            sincePulse = 0;
        end
    endtask

    task automatic driveInputs();
        int v;
        if (mIsFetch) begin
            if (!firstFetch) begin
                if (haltMode) begin
                    opcode = OP_HALT;
                end else begin
                    // 25 defined opcodes plus a few undefined ones
                    drawBits(5, v);
                    opcode = opcodeT'(v[5:0]);
                end
            end
            firstFetch = 1'b0;
            pCls    = decodeClass(opcode);
            pBranch = branchFor(opcode);
            pStack  = stackFor(pCls);
            pSrc    = int'(!(pCls == C_ALU_R || pCls == C_HALT || pCls == C_NOP));
            if (pCls == C_ALU_I) begin
                pAlu = int'(opcode) & 15;
            end else begin
                pAlu = pSrc;
            end
            if (pCls == C_HALT) begin
                drawBits(5, v);
                if (haltMode) begin
                    mWait = (haltIndex == 0) ? 0 : 1 + v % HALT_WAIT_MAX;
                    haltIndex++;
                end else begin
                    mWait = v % (HALT_WAIT_MAX + 1);
                end
            end
            drawBits(1, v);
            intr = (pCls == C_HALT && mWait == 0) ? 1'b1 : v[0];
        end else if (mCls == C_HALT && mStep == 0) begin
            if (mWait == 0) begin
                intr = 1'b1;
            end else begin
                intr = 1'b0;
                mWait--;
            end
        end else begin
            drawBits(1, v);
            intr = v[0];
        end
    endtask

    // Model state change at the rising edge
    task automatic advanceModel();
        if (mIsFetch) begin
            mIsFetch     = 1'b0;
            mPulse       = 1'b0;
            mStep        = 0;
            mCls         = pCls;
            eBranch      = pBranch;
            eAlu         = pAlu;
            eSrc         = pSrc;
            eStack       = pStack;
            mInstrCycles = 1;
        end else begin
            mInstrCycles++;
            mPulse = 1'b0;
            if (mStep == stepsFor(mCls) - 1) begin
                mIsFetch = 1'b1;
                mPulse   = 1'b1;
                lastLen  = mInstrCycles;
                instrDone++;
            end else if (!(mCls == C_HALT && mStep == 0 && intr == 1'b0)) begin
                mStep++;
            end
        end
    endtask

    task automatic cycleOnce();
        compareOutputs();
        driveInputs();
        advanceModel();
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int errStart;
        lfsrState  = 32'hd5d85934;
        errors     = 0;
        checks     = 0;
        cycleCount = 0;
        mIsFetch   = 1'b1;
        mPulse     = 1'b0;
        firstFetch = 1'b1;
        haltMode   = 1'b0;
        havePulse  = 1'b0;
        mStep      = 0;
        mCls       = C_NOP;
        mWait      = 0;
        lastLen    = 0;
        sincePulse = 0;
        instrDone  = 0;
        haltIndex  = 0;
        eBranch    = 0;
        eAlu       = 0;
        eSrc       = 0;
        eStack     = 0;
        rstN       = 1'b0;
        intr       = 1'b0;
        opcode     = OP_LD;

        errStart = errors;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            compareOutputs();
        end
        rstN = 1'b1;
        // First fetch after reset, no PC update expected here
        driveInputs();
        advanceModel();
        @(negedge clk);
        $display("Test reset finished with %0d errors", errors - errStart);

        errStart = errors;
        while (instrDone < NUM_RANDOM) begin
            cycleOnce();
        end
        $display("Test random finished with %0d errors", errors - errStart);

        errStart = errors;
        haltMode = 1'b1;
        while (instrDone < TOTAL_INSTR) begin
            cycleOnce();
        end
        compareOutputs();
        $display("Test halt finished with %0d errors", errors - errStart);

        $display("Tests run: 3, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/isaPkg.sv
src/ctrlPkg.sv
src/opcodeDecoder.sv
src/stepCounter.sv
src/strobeScheduler.sv
src/controlUnit.sv
tb/controlUnit_chk.sv
tb/tbControlUnit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbControlUnit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); exit $$st
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
